/* Bender.yml */
package:
  name: du

sources:
  - src/du_pkg.sv
  - src/du_cmd_ctrl.sv
  - src/du_prog_loader.sv
  - src/du_reply_tx.sv
  - src/du_top.sv
  - target: test
    files:
      - testbench/du_tb.sv

/* src/du_cmd_ctrl.sv */
module du_cmd_ctrl (
    input  logic               i_du_clk,
    input  logic               i_du_reset,
    input  du_pkg::byte_t      i_rx_byte,
    input  logic               i_rx_empty,
    input  logic               i_cpu_halt,
    input  logic               i_load_done,
    input  logic               i_reply_busy,
    output logic               o_rx_read,
    output logic               o_load_start,
    output logic               o_byte_take,
    output logic               o_reply_start,
    output du_pkg::reply_src_t o_reply_src,
    output logic               o_cpu_clk_en,
    output logic               o_cpu_reset,
    output du_pkg::reg_addr_t  o_reg_addr,
    output du_pkg::mem_addr_t  o_mem_addr
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        CORE_RESET,
        GET_REG_ADDR,
        GET_MEM_ADDR,
        GET_LATCH,
        REPLY
    } du_state_t;

    du_state_t state;
    du_state_t next_state;
    logic      rx_valid;

    assign rx_valid = !i_rx_empty;   // FWFT, byte on i_rx_byte is usable now

    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Readback addresses hold until the next read of the same kind
    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            o_reg_addr <= '0;
            o_mem_addr <= '0;
        end else if (rx_valid) begin
            if (state == GET_REG_ADDR) begin
                o_reg_addr <= du_pkg::reg_addr_t'(i_rx_byte);   // Low 5 bits
            end
            if (state == GET_MEM_ADDR) begin
                o_mem_addr <= i_rx_byte;
            end
        end
    end

    always_comb begin
        next_state    = state;
        o_rx_read     = 1'b0;
        o_load_start  = 1'b0;
        o_byte_take   = 1'b0;
        o_reply_start = 1'b0;
        o_reply_src   = du_pkg::REPLY_REG;
        case (state)
            IDLE: begin
                if (rx_valid) begin
                    o_rx_read = 1'b1;
                    case (i_rx_byte)
                        du_pkg::CMD_LOAD_PROG: begin
                            o_load_start = 1'b1;
                            next_state   = LOAD;
                        end
                        du_pkg::CMD_RUN:        next_state = RUN;
                        du_pkg::CMD_RESET:      next_state = CORE_RESET;
                        du_pkg::CMD_READ_REG:   next_state = GET_REG_ADDR;
                        du_pkg::CMD_READ_MEM:   next_state = GET_MEM_ADDR;
                        du_pkg::CMD_READ_LATCH: next_state = GET_LATCH;
                        default:                next_state = IDLE;   // Unknown, dropped
                    endcase
                end
            end
            LOAD: begin
                // Halt word written this cycle, leave the next byte for IDLE
                if (i_load_done) begin
                    next_state = IDLE;
                end else if (rx_valid) begin
                    o_rx_read   = 1'b1;
                    o_byte_take = 1'b1;
                end
            end
            RUN: begin
                if (i_cpu_halt) begin
                    next_state = IDLE;
                end
            end
            CORE_RESET: begin
                next_state = IDLE;
            end
            GET_REG_ADDR: begin
                if (rx_valid) begin
                    o_rx_read     = 1'b1;
                    o_reply_start = 1'b1;
                    o_reply_src   = du_pkg::REPLY_REG;
                    next_state    = REPLY;
                end
            end
            GET_MEM_ADDR: begin
                if (rx_valid) begin
                    o_rx_read     = 1'b1;
                    o_reply_start = 1'b1;
                    o_reply_src   = du_pkg::REPLY_MEM;
                    next_state    = REPLY;
                end
            end
            GET_LATCH: begin
                if (rx_valid) begin
                    o_rx_read  = 1'b1;
                    next_state = IDLE;   // Unknown sub-code sends nothing
                    if (i_rx_byte == du_pkg::SUB_IFID) begin
                        o_reply_start = 1'b1;
                        o_reply_src   = du_pkg::REPLY_IFID;
                        next_state    = REPLY;
                    end else if (i_rx_byte == du_pkg::SUB_MWB) begin
                        o_reply_start = 1'b1;
                        o_reply_src   = du_pkg::REPLY_MWB;
                        next_state    = REPLY;
                    end
                end
            end
            REPLY: begin
                if (!i_reply_busy) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign o_cpu_clk_en = (state == RUN);
    assign o_cpu_reset  = (state == CORE_RESET);   // One cycle, state always moves on

endmodule

/* src/du_pkg.sv */
package du_pkg;

    typedef logic [7:0]  byte_t;        // FIFO data byte
    typedef logic [31:0] word_t;        // Register, memory or instruction word
    typedef logic [4:0]  reg_addr_t;    // Register file index
    typedef logic [7:0]  mem_addr_t;    // Byte address into data or instruction memory

    // Command bytes
    localparam byte_t CMD_LOAD_PROG  = 8'h02;
    localparam byte_t CMD_RUN        = 8'h05;
    localparam byte_t CMD_READ_REG   = 8'h06;
    localparam byte_t CMD_READ_MEM   = 8'h07;
    localparam byte_t CMD_READ_LATCH = 8'h08;
    localparam byte_t CMD_RESET      = 8'h0F;

    // Latch selectors after CMD_READ_LATCH
    localparam byte_t SUB_IFID = 8'h09;
    localparam byte_t SUB_MWB  = 8'h0C;

    localparam word_t HALT_WORD = 32'hFC00_0000;    // Last word of every program

    typedef struct packed {
        word_t pc_plus_4;
        word_t instruction;
    } ifid_latch_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     alu_result;
        word_t     read_data;
        logic      reg_write;
        logic      mem_to_reg;
        logic      is_jal;
        word_t     pc_plus_8;
    } mwb_latch_t;

    localparam int IFID_BYTES = 8;      // 64 bits
    localparam int MWB_BYTES  = 13;     // 104 bits, the longest reply

    typedef enum logic [1:0] {
        REPLY_REG,
        REPLY_MEM,
        REPLY_IFID,
        REPLY_MWB
    } reply_src_t;

endpackage

/* src/du_prog_loader.sv */
module du_prog_loader (
    input  logic              i_du_clk,
    input  logic              i_du_reset,
    input  logic              i_load_start,
    input  logic              i_byte_take,
    input  du_pkg::byte_t     i_byte,
    output logic              o_imem_we,
    output du_pkg::mem_addr_t o_imem_addr,
    output du_pkg::word_t     o_imem_data,
    output logic              o_load_done
);

    du_pkg::word_t shift_q;
    du_pkg::word_t next_word;
    logic [1:0]    byte_cnt;
    logic          word_last;

    assign next_word = {shift_q[23:0], i_byte};       // MSB first
    assign word_last = i_byte_take && (byte_cnt == 2'd3);

    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            byte_cnt    <= '0;
            o_imem_we   <= 1'b0;
            o_imem_addr <= '0;
        end else begin
            o_imem_we <= word_last;
            if (i_load_start) begin
                byte_cnt    <= '0;
                o_imem_addr <= '0;
            end else begin
                if (i_byte_take) begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
                if (o_imem_we) begin
                    o_imem_addr <= o_imem_addr + 8'd4;   // Step after the write cycle
                end
            end
        end
    end

    // Separate from shift_q so the next word can stream in during the write
    always_ff @(posedge i_du_clk) begin
        if (i_byte_take) begin
            shift_q <= next_word;
        end
        if (word_last) begin
            o_imem_data <= next_word;
        end
    end

    assign o_load_done = o_imem_we && (o_imem_data == du_pkg::HALT_WORD);

endmodule

/* src/du_reply_tx.sv */
module du_reply_tx (
    input  logic                i_du_clk,
    input  logic                i_du_reset,
    input  logic                i_reply_start,
    input  du_pkg::reply_src_t  i_reply_src,
    input  du_pkg::word_t       i_reg_data,
    input  du_pkg::word_t       i_mem_data,
    input  du_pkg::ifid_latch_t i_ifid,
    input  du_pkg::mwb_latch_t  i_mwb,
    input  logic                i_tx_full,
    output du_pkg::byte_t       o_tx_byte,
    output logic                o_tx_write,
    output logic                o_busy
);

    du_pkg::reply_src_t             src_q;
    logic [3:0]                     byte_idx;
    logic [3:0]                     last_idx;
    logic [du_pkg::MWB_BYTES*8-1:0] tx_image;

    // Source left-justified in the widest image so byte 0 is always the MSB
    always_comb begin
        case (src_q)
            du_pkg::REPLY_MEM: begin
                tx_image = {i_mem_data, {(du_pkg::MWB_BYTES*8 - $bits(du_pkg::word_t)){1'b0}}};
                last_idx = 4'($bits(du_pkg::word_t)/8 - 1);
            end
            du_pkg::REPLY_IFID: begin
                tx_image = {i_ifid, {((du_pkg::MWB_BYTES - du_pkg::IFID_BYTES)*8){1'b0}}};
                last_idx = 4'(du_pkg::IFID_BYTES - 1);
            end
            du_pkg::REPLY_MWB: begin
                tx_image = i_mwb;
                last_idx = 4'(du_pkg::MWB_BYTES - 1);
            end
            default: begin
                tx_image = {i_reg_data, {(du_pkg::MWB_BYTES*8 - $bits(du_pkg::word_t)){1'b0}}};
                last_idx = 4'($bits(du_pkg::word_t)/8 - 1);
            end
        endcase
    end

    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            o_busy   <= 1'b0;
            byte_idx <= '0;
            src_q    <= du_pkg::REPLY_REG;
        end else if (i_reply_start) begin
            o_busy   <= 1'b1;
            byte_idx <= '0;
            src_q    <= i_reply_src;
        end else if (o_tx_write) begin
            if (byte_idx == last_idx) begin
                o_busy   <= 1'b0;
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + 4'd1;
            end
        end
    end

    assign o_tx_write = o_busy && !i_tx_full;   // Holds its place while full
    assign o_tx_byte  = tx_image[8*(du_pkg::MWB_BYTES - 1 - int'(byte_idx)) +: 8];

endmodule

/* src/du_top.sv */
module du_top (
    input  logic                i_du_clk,
    input  logic                i_du_reset,
    input  du_pkg::byte_t       i_rx_byte,
    input  logic                i_rx_empty,
    input  logic                i_tx_full,
    input  logic                i_cpu_halt,
    input  du_pkg::word_t       i_reg_data,
    input  du_pkg::word_t       i_mem_data,
    input  du_pkg::ifid_latch_t i_ifid,
    input  du_pkg::mwb_latch_t  i_mwb,
    output logic                o_rx_read,
    output du_pkg::byte_t       o_tx_byte,
    output logic                o_tx_write,
    output logic                o_imem_we,
    output du_pkg::mem_addr_t   o_imem_addr,
    output du_pkg::word_t       o_imem_data,
    output logic                o_cpu_clk_en,
    output logic                o_cpu_reset,
    output du_pkg::reg_addr_t   o_reg_addr,
    output du_pkg::mem_addr_t   o_mem_addr
);

    logic               load_start;
    logic               byte_take;
    logic               load_done;
    logic               reply_start;
    du_pkg::reply_src_t reply_src;
    logic               reply_busy;

    du_cmd_ctrl u_cmd_ctrl (
        .i_du_clk      (i_du_clk),
        .i_du_reset    (i_du_reset),
        .i_rx_byte     (i_rx_byte),
        .i_rx_empty    (i_rx_empty),
        .i_cpu_halt    (i_cpu_halt),
        .i_load_done   (load_done),
        .i_reply_busy  (reply_busy),
        .o_rx_read     (o_rx_read),
        .o_load_start  (load_start),
        .o_byte_take   (byte_take),
        .o_reply_start (reply_start),
        .o_reply_src   (reply_src),
        .o_cpu_clk_en  (o_cpu_clk_en),
        .o_cpu_reset   (o_cpu_reset),
        .o_reg_addr    (o_reg_addr),
        .o_mem_addr    (o_mem_addr)
    );

    du_prog_loader u_prog_loader (
        .i_du_clk     (i_du_clk),
        .i_du_reset   (i_du_reset),
        .i_load_start (load_start),
        .i_byte_take  (byte_take),
        .i_byte       (i_rx_byte),     // Same FWFT byte the controller decodes
        .o_imem_we    (o_imem_we),
        .o_imem_addr  (o_imem_addr),
        .o_imem_data  (o_imem_data),
        .o_load_done  (load_done)
    );

    du_reply_tx u_reply_tx (
        .i_du_clk      (i_du_clk),
        .i_du_reset    (i_du_reset),
        .i_reply_start (reply_start),
        .i_reply_src   (reply_src),
        .i_reg_data    (i_reg_data),
        .i_mem_data    (i_mem_data),
        .i_ifid        (i_ifid),
        .i_mwb         (i_mwb),
        .i_tx_full     (i_tx_full),
        .o_tx_byte     (o_tx_byte),
        .o_tx_write    (o_tx_write),
        .o_busy        (reply_busy)
    );

endmodule

/* tb.f */
src/du_pkg.sv
src/du_cmd_ctrl.sv
src/du_prog_loader.sv
src/du_reply_tx.sv
src/du_top.sv
testbench/du_tb.sv

/* testbench/du_tb.sv */
module du_tb;

    localparam int TIMEOUT = 3000;   // Cycles allowed for any single wait

    logic                i_du_clk;
    logic                i_du_reset;
    du_pkg::byte_t       i_rx_byte;
    logic                i_rx_empty;
    logic                i_tx_full;
    logic                i_cpu_halt;
    du_pkg::word_t       i_reg_data;
    du_pkg::word_t       i_mem_data;
    du_pkg::ifid_latch_t i_ifid;
    du_pkg::mwb_latch_t  i_mwb;
    logic                o_rx_read;
    du_pkg::byte_t       o_tx_byte;
    logic                o_tx_write;
    logic                o_imem_we;
    du_pkg::mem_addr_t   o_imem_addr;
    du_pkg::word_t       o_imem_data;
    logic                o_cpu_clk_en;
    logic                o_cpu_reset;
    du_pkg::reg_addr_t   o_reg_addr;
    du_pkg::mem_addr_t   o_mem_addr;

    du_pkg::byte_t     rx_queue[$];        // Receive FIFO model
    du_pkg::byte_t     tx_log[$];          // Bytes accepted by the transmit FIFO
    du_pkg::byte_t     exp_q[$];
    du_pkg::mem_addr_t imem_addr_log[$];
    du_pkg::word_t     imem_data_log[$];
    logic [31:0]       drv_seed;
    logic [31:0]       tst_seed;
    logic              pressure_on;
    logic              rx_read_seen;
    logic              clk_en_seen;
    logic              ctrl_seen;
    du_pkg::reg_addr_t reg_addr_seen;
    du_pkg::mem_addr_t mem_addr_seen;
    int                cycle_cnt;
    int                rx_sent;
    int                rx_consumed;
    int                last_read_cycle;
    int                reset_pulses;
    int                reset_cycle;
    int                clk_en_rise_cycle;
    int                errors;
    int                tests_run;
    int                tests_failed;
    int                test_err_start;

    du_top uut (.*);

    always #10 i_du_clk = ~i_du_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_command(input du_pkg::byte_t b);
        return b == du_pkg::CMD_LOAD_PROG || b == du_pkg::CMD_RUN || b == du_pkg::CMD_RESET ||
               b == du_pkg::CMD_READ_REG || b == du_pkg::CMD_READ_MEM ||
               b == du_pkg::CMD_READ_LATCH;
    endfunction

    // Outputs are sampled mid-cycle, the rest of the bench reads these after the next rise
    always @(negedge i_du_clk) begin
        cycle_cnt = cycle_cnt + 1;
        rx_read_seen = o_rx_read;
        if (o_rx_read) begin
            if (i_rx_empty) begin
                $display("error at %0t: read strobe while the receive FIFO is empty", $time);
                errors++;
            end
            rx_consumed++;
            last_read_cycle = cycle_cnt;
        end
        if (o_tx_write) begin
            if (i_tx_full) begin
                $display("error at %0t: write strobe while the transmit FIFO is full", $time);
                errors++;
            end
            tx_log.push_back(o_tx_byte);
        end
        if (o_imem_we) begin
            imem_addr_log.push_back(o_imem_addr);
            imem_data_log.push_back(o_imem_data);
        end
        if (o_cpu_reset) begin
            reset_pulses++;
            reset_cycle = cycle_cnt;
        end
        if (o_cpu_clk_en && !clk_en_seen) begin
            clk_en_rise_cycle = cycle_cnt;
        end
        clk_en_seen = o_cpu_clk_en;
        ctrl_seen = o_rx_read | o_tx_write | o_imem_we | o_cpu_reset | o_cpu_clk_en;
        reg_addr_seen = o_reg_addr;
        mem_addr_seen = o_mem_addr;
    end

    // FWFT receive side with random gaps, plus transmit back-pressure
    always @(posedge i_du_clk) begin
        drv_seed = lcg_next(drv_seed);
        if (rx_read_seen && rx_queue.size() > 0) begin
            void'(rx_queue.pop_front());
        end
        if (rx_queue.size() > 0 && drv_seed[31:30] != 2'b00) begin
            i_rx_empty <= 1'b0;
            i_rx_byte  <= rx_queue[0];
        end else begin
            i_rx_empty <= 1'b1;
        end
        i_tx_full <= pressure_on && drv_seed[27];   // Full about half the time
    end

    task automatic rand_word(output du_pkg::word_t w);
        tst_seed = lcg_next(tst_seed);
        w[31:16] = tst_seed[31:16];
        tst_seed = lcg_next(tst_seed);
        w[15:0] = tst_seed[31:16];
    endtask

    task automatic rand_byte(output du_pkg::byte_t b);
        tst_seed = lcg_next(tst_seed);
        b = tst_seed[31:24];
    endtask

    task automatic send_byte(input du_pkg::byte_t b);
        @(negedge i_du_clk);
        rx_queue.push_back(b);
        rx_sent++;
    endtask

    task automatic send_word(input du_pkg::word_t w);
        for (int k = 3; k >= 0; k--) begin
            send_byte(w[8*k +: 8]);
        end
    endtask

    task automatic wait_tx_bytes(input int n);
        int waited;
        waited = 0;
        @(posedge i_du_clk);
        while (tx_log.size() < n && waited < TIMEOUT) begin
            @(posedge i_du_clk);
            waited++;
        end
        if (tx_log.size() < n) begin
            $display("timeout at %0t: only %0d of %0d reply bytes arrived", $time,
                     tx_log.size(), n);
            errors++;
        end
    endtask

    // Waits until every queued byte is consumed, then leaves a short quiet window
    task automatic drain_rx;
        int waited;
        waited = 0;
        @(posedge i_du_clk);
        while (rx_consumed != rx_sent && waited < TIMEOUT) begin
            @(posedge i_du_clk);
            waited++;
        end
        if (rx_consumed != rx_sent) begin
            $display("timeout at %0t: the DUT stopped reading command bytes", $time);
            errors++;
        end
        repeat (6) @(posedge i_du_clk);
    endtask

    task automatic expect_image(input logic [103:0] img, input int n);
        exp_q.delete();
        for (int k = 0; k < n; k++) begin
            exp_q.push_back(img[8*(n-1-k) +: 8]);
        end
    endtask

    task automatic check_reply(input string what);
        if (tx_log.size() != exp_q.size()) begin
            $display("mismatch at %0t: %s sent %0d bytes, expected %0d", $time, what,
                     tx_log.size(), exp_q.size());
            errors++;
        end else begin
            for (int k = 0; k < exp_q.size(); k++) begin
                if (tx_log[k] !== exp_q[k]) begin
                    $display("mismatch at %0t: %s byte %0d is %h, expected %h", $time, what,
                             k, tx_log[k], exp_q[k]);
                    errors++;
                end
            end
        end
    endtask

    task automatic start_test(input logic pressure);
        @(posedge i_du_clk);
        pressure_on <= pressure;
        test_err_start = errors;
        tx_log.delete();
        imem_addr_log.delete();
        imem_data_log.delete();
        reset_pulses = 0;
        clk_en_rise_cycle = -1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end
    endtask

    task automatic readback(input du_pkg::byte_t cmd, input du_pkg::byte_t addr);
        du_pkg::word_t w;
        rand_word(w);
        @(posedge i_du_clk);
        if (cmd == du_pkg::CMD_READ_REG) begin
            i_reg_data <= w;
        end else begin
            i_mem_data <= w;
        end
        tx_log.delete();
        expect_image({72'b0, w}, 4);
        send_byte(cmd);
        send_byte(addr);
        wait_tx_bytes(4);
        drain_rx();
        check_reply(cmd == du_pkg::CMD_READ_REG ? "register read" : "memory read");
        if (cmd == du_pkg::CMD_READ_REG && reg_addr_seen !== addr[4:0]) begin
            $display("mismatch at %0t: register address %h, expected %h", $time,
                     reg_addr_seen, addr[4:0]);
            errors++;
        end
        if (cmd == du_pkg::CMD_READ_MEM && mem_addr_seen !== addr) begin
            $display("mismatch at %0t: memory address %h, expected %h", $time,
                     mem_addr_seen, addr);
            errors++;
        end
    endtask

    task automatic latch_read(input du_pkg::byte_t sub, input logic [103:0] img, input int n);
        @(posedge i_du_clk);
        tx_log.delete();
        expect_image(img, n);
        send_byte(du_pkg::CMD_READ_LATCH);
        send_byte(sub);
        wait_tx_bytes(n);
        drain_rx();
        check_reply("latch dump");
    endtask

    task automatic test_load;
        du_pkg::word_t words[$];
        du_pkg::word_t w;
        du_pkg::byte_t b;
        int            n_words;
        int            waited;
        start_test(1'b0);
        if (ctrl_seen !== 1'b0 || reg_addr_seen !== '0 || mem_addr_seen !== '0) begin
            $display("mismatch at %0t: outputs not idle after reset", $time);
            errors++;
        end
        tst_seed = lcg_next(tst_seed);
        n_words = 4 + tst_seed[31:16] % 5;
        send_byte(du_pkg::CMD_LOAD_PROG);
        for (int i = 0; i < n_words; i++) begin
            rand_word(w);
            if (w == du_pkg::HALT_WORD) begin
                w = ~w;
            end
            words.push_back(w);
            send_word(w);
        end
        words.push_back(du_pkg::HALT_WORD);
        send_word(du_pkg::HALT_WORD);
        for (int i = 0; i < 4; i++) begin
            rand_byte(b);
            while (is_command(b)) begin
                b = b + 8'd1;
            end
            send_byte(b);   // Dropped as unknown commands once the load is over
        end
        waited = 0;
        @(posedge i_du_clk);
        while (imem_data_log.size() < words.size() && waited < TIMEOUT) begin
            @(posedge i_du_clk);
            waited++;
        end
        if (imem_data_log.size() < words.size()) begin
            $display("timeout at %0t: program load wrote only %0d words", $time,
                     imem_data_log.size());
            errors++;
        end
        drain_rx();
        if (imem_data_log.size() != words.size()) begin
            $display("mismatch at %0t: %0d imem writes, expected %0d", $time,
                     imem_data_log.size(), words.size());
            errors++;
        end else begin
            for (int i = 0; i < words.size(); i++) begin
                if (imem_addr_log[i] !== 8'(4*i) || imem_data_log[i] !== words[i]) begin
                    $display("mismatch at %0t: imem write %0d at %h data %h, expected %h data %h",
                             $time, i, imem_addr_log[i], imem_data_log[i], 8'(4*i), words[i]);
                    errors++;
                end
            end
        end
        finish_test("program load");
    endtask

    task automatic test_latches;
        du_pkg::word_t w0;
        du_pkg::word_t w1;
        du_pkg::word_t w2;
        du_pkg::word_t w3;
        du_pkg::byte_t sub;
        start_test(1'b1);
        rand_word(w0);
        rand_word(w1);
        rand_word(w2);
        rand_word(w3);
        i_ifid <= {w0, w1};
        i_mwb  <= {w1, w2, w3, w0[15:8]};
        latch_read(du_pkg::SUB_IFID, {40'b0, w0, w1}, du_pkg::IFID_BYTES);
        latch_read(du_pkg::SUB_MWB, {w1, w2, w3, w0[15:8]}, du_pkg::MWB_BYTES);
        rand_byte(sub);
        if (sub == du_pkg::SUB_IFID || sub == du_pkg::SUB_MWB) begin
            sub = sub + 8'd1;
        end
        latch_read(sub, '0, 0);
        readback(du_pkg::CMD_READ_REG, sub);    // Controller must be back in idle
        finish_test("latch dump");
    endtask

    task automatic test_core_control;
        int waited;
        int hold;
        start_test(1'b0);
        send_byte(du_pkg::CMD_RUN);
        waited = 0;
        @(posedge i_du_clk);
        while (clk_en_rise_cycle < 0 && waited < TIMEOUT) begin
            @(posedge i_du_clk);
            waited++;
        end
        if (clk_en_rise_cycle < 0) begin
            $display("timeout at %0t: core clock enable never went high", $time);
            errors++;
        end else if (clk_en_rise_cycle != last_read_cycle + 1) begin
            $display("mismatch at %0t: clock enable rose in cycle %0d, expected %0d", $time,
                     clk_en_rise_cycle, last_read_cycle + 1);
            errors++;
        end
        tst_seed = lcg_next(tst_seed);
        hold = 3 + tst_seed[31:16] % 6;
        repeat (hold) begin
            @(posedge i_du_clk);
            if (clk_en_seen !== 1'b1) begin
                $display("mismatch at %0t: clock enable dropped before halt", $time);
                errors++;
            end
        end
        i_cpu_halt <= 1'b1;
        @(posedge i_du_clk);
        if (clk_en_seen !== 1'b1) begin
            $display("mismatch at %0t: clock enable low in the halt cycle", $time);
            errors++;
        end
        i_cpu_halt <= 1'b0;
        @(posedge i_du_clk);
        if (clk_en_seen !== 1'b0) begin
            $display("mismatch at %0t: clock enable still high after halt", $time);
            errors++;
        end
        send_byte(du_pkg::CMD_RESET);
        waited = 0;
        @(posedge i_du_clk);
        while (reset_pulses == 0 && waited < TIMEOUT) begin
            @(posedge i_du_clk);
            waited++;
        end
        drain_rx();
        if (reset_pulses != 1) begin
            $display("mismatch at %0t: %0d core reset cycles, expected 1", $time, reset_pulses);
            errors++;
        end else if (reset_cycle != last_read_cycle + 1) begin
            $display("mismatch at %0t: core reset in cycle %0d, expected %0d", $time,
                     reset_cycle, last_read_cycle + 1);
            errors++;
        end
        finish_test("core control");
    endtask

    task automatic test_unknown;
        du_pkg::byte_t b;
        start_test(1'b1);
        rand_byte(b);
        while (is_command(b)) begin
            b = b + 8'd1;
        end
        send_byte(b);
        drain_rx();
        if (tx_log.size() != 0 || imem_data_log.size() != 0 || reset_pulses != 0 ||
            clk_en_rise_cycle != -1) begin
            $display("mismatch at %0t: unknown command %h caused output activity", $time, b);
            errors++;
        end
        rand_byte(b);
        readback(du_pkg::CMD_READ_REG, b);
        finish_test("unknown command");
    endtask

    initial begin
        du_pkg::byte_t a;
        i_du_clk          = 1'b0;
        i_du_reset        = 1'b1;
        i_rx_byte         = '0;
        i_rx_empty        = 1'b1;
        i_tx_full         = 1'b0;
        i_cpu_halt        = 1'b0;
        i_reg_data        = '0;
        i_mem_data        = '0;
        i_ifid            = '0;
        i_mwb             = '0;
        drv_seed          = 32'd93;
        tst_seed          = 32'd93;
        pressure_on       = 1'b0;
        rx_read_seen      = 1'b0;
        clk_en_seen       = 1'b0;
        ctrl_seen         = 1'b0;
        cycle_cnt         = 0;
        rx_sent           = 0;
        rx_consumed       = 0;
        last_read_cycle   = -1;
        reset_pulses      = 0;
        reset_cycle       = -1;
        clk_en_rise_cycle = -1;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        repeat (3) @(posedge i_du_clk);
        i_du_reset <= 1'b0;
        test_load();
        start_test(1'b1);
        for (int i = 0; i < 3; i++) begin
            rand_byte(a);
            readback(du_pkg::CMD_READ_REG, a);
        end
        finish_test("register read");
        start_test(1'b1);
        for (int i = 0; i < 3; i++) begin
            rand_byte(a);
            readback(du_pkg::CMD_READ_MEM, a);
        end
        finish_test("memory read");
        test_latches();
        test_core_control();
        test_unknown();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
